/* soc_periph_testdata.txt */
// columns: op addr data expected_rdata expected_pslverr
// op 1 write, 2 read, 3 pins {irq_spi, irq_uart, gpio[5:0]}, 4 output (0 out, 1 oe, 2 irq), 0 end
// output and direction registers
1 10002000 000000e5 00000000 0
4 00000000 00000000 00000025 0
2 10002000 00000000 00000025 0
1 10002004 0000003c 00000000 0
4 00000001 00000000 0000003c 0
2 10002004 00000000 0000003c 0
// input register ignores writes
1 10002008 000000ff 00000000 0
2 10002008 00000000 00000000 0
// pins and both interrupt lines, no edge enabled yet
3 00000000 000000c9 00000000 0
2 10002008 00000000 000000c9 0
2 10002010 00000000 00000000 0
4 00000002 00000000 00000000 0
// enable the uart line and pin 0
1 1000200c 00000041 00000000 0
2 1000200c 00000000 00000041 0
3 00000000 00000000 00000000 0
2 10002010 00000000 00000000 0
3 00000000 00000040 00000000 0
2 10002010 00000000 00000040 0
4 00000002 00000000 00000001 0
// pin 1 rises but is masked
3 00000000 00000042 00000000 0
2 10002010 00000000 00000040 0
1 10002010 00000040 00000000 0
2 10002010 00000000 00000000 0
4 00000002 00000000 00000000 0
// spi line on its own
1 1000200c 00000080 00000000 0
3 00000000 000000c2 00000000 0
2 10002008 00000000 000000c2 0
2 10002010 00000000 00000080 0
4 00000002 00000000 00000001 0
1 10002010 000000ff 00000000 0
4 00000002 00000000 00000000 0
// unknown offsets inside the gpio window
2 10002020 00000000 00000000 0
1 10002ffc 0000003f 00000000 0
2 10002000 00000000 00000025 0
// unmapped space
1 10000000 12345678 00000000 1
2 10000004 00000000 00000000 1
1 10001000 0000005a 00000000 1
2 10001008 00000000 00000000 1
2 00000000 00000000 00000000 1
2 10003000 00000000 00000000 1
2 fffffffc 00000000 00000000 1
0 00000000 00000000 00000000 0

/* list.f */
soc_pkg.sv
apb_if.sv
core_reset_sync.sv
clk_mon_div8.sv
apb_decoder.sv
gpio_apb.sv
soc_periph_top.sv
tb_soc_periph.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_soc_periph -f list.f

status=0
./obj_dir/Vtb_soc_periph > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
echo "simulation passed"

/* tb_soc_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;
  import soc_pkg::*;

  localparam int GPIO_W         = 6;
  localparam int RESET_CYCLES   = 16;
  localparam int MON_EDGES      = 20;
  localparam int MAX_STEPS      = 64;
  localparam int WORDS_PER_STEP = 5;
  localparam int READY_LIMIT    = 8;
  localparam logic [31:0] SEED  = 32'hce4c_1800;

  // step opcodes of the data file
  localparam logic [31:0] OP_END   = 32'd0;
  localparam logic [31:0] OP_WRITE = 32'd1;
  localparam logic [31:0] OP_READ  = 32'd2;
  localparam logic [31:0] OP_PINS  = 32'd3;
  localparam logic [31:0] OP_OUT   = 32'd4;

  logic                  dev_clk;
  logic                  reset_n;
  logic [APB_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic [GPIO_W-1:0]     gpio_in;
  logic [GPIO_W-1:0]     gpio_out;
  logic [GPIO_W-1:0]     gpio_oe;
  logic                  irq_uart;
  logic                  irq_spi;
  logic                  irq;
  logic                  core_rst_n;
  logic                  core_clk_mon;

  int          errors;
  int          checks;
  int          num_steps;
  logic        load_done;
  logic [31:0] step_mem [0:MAX_STEPS*WORDS_PER_STEP-1];

  soc_periph_top #(
    .GPIO_W (GPIO_W)
  ) i_dut (
    .dev_clk        (dev_clk),
    .reset_n        (reset_n),
    .paddr_i        (paddr),
    .psel_i         (psel),
    .penable_i      (penable),
    .pwrite_i       (pwrite),
    .pwdata_i       (pwdata),
    .prdata_o       (prdata),
    .pready_o       (pready),
    .pslverr_o      (pslverr),
    .gpio_i         (gpio_in),
    .gpio_o         (gpio_out),
    .gpio_oe_o      (gpio_oe),
    .irq_uart_i     (irq_uart),
    .irq_spi_i      (irq_spi),
    .irq_o          (irq),
    .core_rst_n_o   (core_rst_n),
    .core_clk_mon_o (core_clk_mon)
  );

  initial begin
    dev_clk = 1'b0;
    forever #2 dev_clk = ~dev_clk;
  end

  // limit scales with the number of steps in the data file
  initial begin
    int limit;
    wait (load_done);
    limit = num_steps * 20 + 200;
    repeat (limit) @(posedge dev_clk);
    $display("watchdog: run still busy after %0d cycles", limit);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // setup phase, then access phase until pready
  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waited;
    @(posedge dev_clk);
    #1;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge dev_clk);
    #1;
    penable = 1'b1;
    @(negedge dev_clk);
    waited = 0;
    while (!pready && waited < READY_LIMIT) begin
      @(negedge dev_clk);
      waited++;
    end
    if (!pready) begin
      $display("no pready from the DUT within %0d cycles at address 0x%h", READY_LIMIT, addr);
      errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge dev_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_reset_values();
    repeat (RESET_CYCLES - 1) begin
      @(posedge dev_clk);
      @(negedge dev_clk);
      check_value("gpio_o", 32'(gpio_out), 32'h0);
      check_value("gpio_oe_o", 32'(gpio_oe), 32'h0);
      check_value("irq_o", 32'(irq), 32'h0);
      check_value("pready_o", 32'(pready), 32'h0);
      check_value("pslverr_o", 32'(pslverr), 32'h0);
      check_value("core_rst_n_o", 32'(core_rst_n), 32'h0);
      check_value("core_clk_mon_o", 32'(core_clk_mon), 32'h0);
    end
    @(posedge dev_clk);
    #1;
    reset_n = 1'b1;
  endtask

  // edge n counts rising edges after release
  task automatic check_release_timing();
    int n;
    for (n = 1; n <= MON_EDGES; n++) begin
      @(posedge dev_clk);
      @(negedge dev_clk);
      check_value("core_rst_n_o", 32'(core_rst_n), (n >= 3) ? 32'h1 : 32'h0);
      check_value("core_clk_mon_o", 32'(core_clk_mon), 32'((n / 4) % 2));
    end
  endtask

  task automatic run_step(input int idx);
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_val;
    logic [31:0] exp_err;
    logic [31:0] rdata;
    logic        err;
    op      = step_mem[idx*WORDS_PER_STEP];
    addr    = step_mem[idx*WORDS_PER_STEP+1];
    data    = step_mem[idx*WORDS_PER_STEP+2];
    exp_val = step_mem[idx*WORDS_PER_STEP+3];
    exp_err = step_mem[idx*WORDS_PER_STEP+4];
    case (op)
      OP_WRITE: begin
        apb_transfer(1'b1, addr, data, rdata, err);
        check_value("pslverr_o", 32'(err), exp_err);
      end
      OP_READ: begin
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
        check_value("prdata_o", rdata, exp_val);
        check_value("pslverr_o", 32'(err), exp_err);
      end
      OP_PINS: begin
        @(posedge dev_clk);
        #1;
        {irq_spi, irq_uart, gpio_in} = data[GPIO_W+1:0];
        // through the synchronizer and the edge detect
        repeat (3) @(posedge dev_clk);
      end
      OP_OUT: begin
        repeat (2) @(posedge dev_clk);
        @(negedge dev_clk);
        case (addr)
          32'd0:   check_value("gpio_o", 32'(gpio_out), exp_val);
          32'd1:   check_value("gpio_oe_o", 32'(gpio_oe), exp_val);
          32'd2:   check_value("irq_o", 32'(irq), exp_val);
          default: begin
            $display("step %0d names an unknown output %0d", idx, addr);
            errors++;
          end
        endcase
      end
      default: begin
        $display("step %0d has an unknown operation %0d", idx, op);
        errors++;
      end
    endcase
  endtask

  initial begin
    int unsigned seed_val;
    int unsigned gap;
    int          i;
    int          s;
    errors    = 0;
    checks    = 0;
    num_steps = 0;
    load_done = 1'b0;
    seed_val  = $urandom(SEED);
    reset_n   = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    gpio_in   = '0;
    irq_uart  = 1'b0;
    irq_spi   = 1'b0;
    for (i = 0; i < MAX_STEPS * WORDS_PER_STEP; i++) begin
      step_mem[i] = '0;
    end
    $readmemh("soc_periph_testdata.txt", step_mem);
    while (num_steps < MAX_STEPS && step_mem[num_steps*WORDS_PER_STEP] != OP_END) begin
      num_steps++;
    end
    if (num_steps == 0) begin
      $display("no steps could be read from the data file");
      errors++;
    end
    load_done = 1'b1;

    check_reset_values();
    check_release_timing();

    for (s = 0; s < num_steps; s++) begin
      gap = $urandom % 4;
      repeat (gap) @(posedge dev_clk);
      run_step(s);
    end
    repeat (4) @(posedge dev_clk);

    $display("closing: %0d checks, %0d errors, seed 0x%h", checks, errors, seed_val);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* soc_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top #(
  parameter int GPIO_W = 6
) (
  input  logic                          dev_clk,
  input  logic                          reset_n,
  input  logic [soc_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [soc_pkg::APB_DATA_W-1:0] pwdata_i,
  output logic [soc_pkg::APB_DATA_W-1:0] prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  input  logic [GPIO_W-1:0]             gpio_i,
  output logic [GPIO_W-1:0]             gpio_o,
  output logic [GPIO_W-1:0]             gpio_oe_o,
  input  logic                          irq_uart_i,
  input  logic                          irq_spi_i,
  output logic                          irq_o,
  output logic                          core_rst_n_o,
  output logic                          core_clk_mon_o
);

  logic [GPIO_W+1:0] gpio_pins;

  apb_if up_bus ();
  apb_if gpio_bus ();

  core_reset_sync u_core_reset_sync (
    .dev_clk      (dev_clk),
    .reset_n      (reset_n),
    .core_rst_n_o (core_rst_n_o)
  );

  clk_mon_div8 u_clk_mon_div8 (
    .dev_clk   (dev_clk),
    .reset_n   (reset_n),
    .clk_mon_o (core_clk_mon_o)
  );

  // external requester onto the internal link
  assign up_bus.paddr   = paddr_i;
  assign up_bus.psel    = psel_i;
  assign up_bus.penable = penable_i;
  assign up_bus.pwrite  = pwrite_i;
  assign up_bus.pwdata  = pwdata_i;
  assign prdata_o       = up_bus.prdata;
  assign pready_o       = up_bus.pready;
  assign pslverr_o      = up_bus.pslverr;

  apb_decoder u_apb_decoder (
    .dev_clk (dev_clk),
    .reset_n (reset_n),
    .up_i    (up_bus.completer),
    .gpio_o  (gpio_bus.requester)
  );

  // uart and spi interrupts ride above the external pins
  assign gpio_pins = {irq_spi_i, irq_uart_i, gpio_i};

  gpio_apb #(
    .GPIO_W (GPIO_W)
  ) u_gpio_apb (
    .dev_clk   (dev_clk),
    .reset_n   (reset_n),
    .bus_i     (gpio_bus.completer),
    .pins_i    (gpio_pins),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .irq_o     (irq_o)
  );

endmodule

`default_nettype wire

/* gpio_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_apb #(
  parameter int GPIO_W = 6
) (
  input  logic              dev_clk,
  input  logic              reset_n,
  apb_if.completer          bus_i,
  input  logic [GPIO_W+1:0] pins_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_oe_o,
  output logic              irq_o
);
  import soc_pkg::*;

  // external pins plus the uart and spi interrupt lines
  localparam int PIN_W = GPIO_W + 2;

  logic [GPIO_W-1:0]     out_q;
  logic [GPIO_W-1:0]     dir_q;
  logic [PIN_W-1:0]      int_en_q;
  logic [PIN_W-1:0]      int_stat_q;
  logic [PIN_W-1:0]      sync1_q;
  logic [PIN_W-1:0]      sync2_q;
  logic [PIN_W-1:0]      sync_d_q;
  logic                  irq_q;
  logic [PIN_W-1:0]      rise;
  logic [PIN_W-1:0]      stat_clr;
  logic                  wr_en;
  gpio_reg_e             reg_off;
  logic [APB_DATA_W-1:0] rd_data;

  assign reg_off = gpio_reg_e'(bus_i.paddr[WIN_W-1:0]);

  // no wait states, so the access phase always ends the transfer
  assign wr_en = bus_i.psel & bus_i.penable & bus_i.pwrite;

  always_ff @(posedge dev_clk or negedge reset_n) begin
    if (!reset_n) begin
      out_q    <= '0;
      dir_q    <= '0;
      int_en_q <= '0;
    end else if (wr_en) begin
      case (reg_off)
        REG_OUT:    out_q    <= bus_i.pwdata[GPIO_W-1:0];
        REG_DIR:    dir_q    <= bus_i.pwdata[GPIO_W-1:0];
        REG_INT_EN: int_en_q <= bus_i.pwdata[PIN_W-1:0];
        default:    ;
      endcase
    end
  end

  // two-flop synchronizer and a delayed copy for edge detect
  always_ff @(posedge dev_clk or negedge reset_n) begin
    if (!reset_n) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      sync_d_q <= '0;
    end else begin
      sync1_q  <= pins_i;
      sync2_q  <= sync1_q;
      sync_d_q <= sync2_q;
    end
  end

  assign rise = sync2_q & ~sync_d_q & int_en_q;

  always_comb begin
    stat_clr = '0;
    if (wr_en && reg_off == REG_INT_STAT) begin
      stat_clr = bus_i.pwdata[PIN_W-1:0];
    end
  end

  // a new edge wins over a clear in the same cycle
  always_ff @(posedge dev_clk or negedge reset_n) begin
    if (!reset_n) begin
      int_stat_q <= '0;
      irq_q      <= 1'b0;
    end else begin
      int_stat_q <= (int_stat_q & ~stat_clr) | rise;
      irq_q      <= |int_stat_q;
    end
  end

  always_comb begin
    rd_data = '0;
    case (reg_off)
      REG_OUT:      rd_data[GPIO_W-1:0] = out_q;
      REG_DIR:      rd_data[GPIO_W-1:0] = dir_q;
      REG_IN:       rd_data[PIN_W-1:0]  = sync2_q;
      REG_INT_EN:   rd_data[PIN_W-1:0]  = int_en_q;
      REG_INT_STAT: rd_data[PIN_W-1:0]  = int_stat_q;
      default:      rd_data = '0;
    endcase
  end

  assign bus_i.prdata  = rd_data;
  assign bus_i.pready  = bus_i.psel & bus_i.penable;
  assign bus_i.pslverr = 1'b0;

  assign gpio_o    = out_q;
  assign gpio_oe_o = dir_q;
  assign irq_o     = irq_q;

  a_irq_follows_stat: assert property (
    @(posedge dev_clk) disable iff (!reset_n)
    ($past(int_stat_q) == '0) |-> !irq_o
  ) else $error("irq_o high with no pending status on the previous edge");

endmodule

`default_nettype wire

/* apb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_decoder (
  input  logic     dev_clk,
  input  logic     reset_n,
  apb_if.completer up_i,
  apb_if.requester gpio_o
);
  import soc_pkg::*;

  logic gpio_win;
  logic spi_win;
  logic uart_win;
  logic access;
  logic err_access;

  function automatic logic in_window(
    input logic [APB_ADDR_W-1:0] addr,
    input logic [APB_ADDR_W-1:0] base
  );
    in_window = (addr[APB_ADDR_W-1:WIN_W] == base[APB_ADDR_W-1:WIN_W]);
  endfunction

  assign gpio_win = in_window(up_i.paddr, GPIO_BASE);
  // spi and uart windows have no target behind them any more
  assign spi_win  = in_window(up_i.paddr, SPI_BASE);
  assign uart_win = in_window(up_i.paddr, UART_BASE);

  assign access     = up_i.psel & up_i.penable;
  assign err_access = access & ~gpio_win;

  // only the GPIO window sees a select
  assign gpio_o.paddr   = up_i.paddr;
  assign gpio_o.psel    = up_i.psel & gpio_win;
  assign gpio_o.penable = up_i.penable & gpio_win;
  assign gpio_o.pwrite  = up_i.pwrite;
  assign gpio_o.pwdata  = up_i.pwdata;

  // unmapped space answers at once with an error
  always_comb begin
    if (gpio_win) begin
      up_i.prdata  = gpio_o.prdata;
      up_i.pready  = gpio_o.pready;
      up_i.pslverr = gpio_o.pslverr;
    end else begin
      up_i.prdata  = '0;
      up_i.pready  = err_access;
      up_i.pslverr = err_access;
    end
  end

  a_psel_mapped: assert property (
    @(posedge dev_clk) disable iff (!reset_n)
    gpio_o.psel |-> !spi_win && !uart_win && in_window(gpio_o.paddr, GPIO_BASE)
  ) else $error("forwarded psel on unmapped address %h", gpio_o.paddr);

  a_penable_psel: assert property (
    @(posedge dev_clk) disable iff (!reset_n)
    up_i.penable |-> up_i.psel
  ) else $error("penable high without psel");

endmodule

`default_nettype wire

/* clk_mon_div8.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_mon_div8 (
  input  logic dev_clk,
  input  logic reset_n,
  output logic clk_mon_o
);

  logic [1:0] cnt_q;
  logic       mon_q;

  // toggle every fourth edge, one eighth of dev_clk
  always_ff @(posedge dev_clk or negedge reset_n) begin
    if (!reset_n) begin
      cnt_q <= 2'd0;
      mon_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 2'd1;
      if (cnt_q == 2'd3) begin
        mon_q <= ~mon_q;
      end
    end
  end

  // brought out to a pad so the PLL can be checked off-chip
  assign clk_mon_o = mon_q;

endmodule

`default_nettype wire

/* core_reset_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module core_reset_sync (
  input  logic dev_clk,
  input  logic reset_n,
  output logic core_rst_n_o
);

  logic rst_s1;
  logic rst_s2;
  logic rst_s3;

  // assert asynchronously, release after three dev_clk edges
  always_ff @(posedge dev_clk or negedge reset_n) begin
    if (!reset_n) begin
      rst_s1 <= 1'b0;
      rst_s2 <= 1'b0;
      rst_s3 <= 1'b0;
    end else begin
      rst_s1 <= 1'b1;
      rst_s2 <= rst_s1;
      rst_s3 <= rst_s2;
    end
  end

  assign core_rst_n_o = rst_s3;

endmodule

`default_nettype wire

/* apb_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface apb_if;
  import soc_pkg::*;

  logic [APB_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  modport requester (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

/* soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // APB link widths
  parameter int APB_ADDR_W = 32;
  parameter int APB_DATA_W = 32;

  // low address bits that fall inside one 4 KB window
  parameter int WIN_W = 12;

  // address map
  parameter logic [APB_ADDR_W-1:0] SPI_BASE  = 32'h1000_0000;
  parameter logic [APB_ADDR_W-1:0] UART_BASE = 32'h1000_1000;
  parameter logic [APB_ADDR_W-1:0] GPIO_BASE = 32'h1000_2000;

  // GPIO register offsets inside the window
  typedef enum logic [WIN_W-1:0] {
    REG_OUT      = 'h00,
    REG_DIR      = 'h04,
    // read only, synchronized pin levels
    REG_IN       = 'h08,
    REG_INT_EN   = 'h0C,
    // write 1 to clear
    REG_INT_STAT = 'h10
  } gpio_reg_e;

endpackage

`default_nettype wire
